/* l1d_tests.txt */
# op addr wdata fill_shared exp_rdata cmd1 cmd2, hex fields, exp_rdata unused for W
# cmd1 cmd2 are the level-2 commands in issue order, - where none
R 00000107 00000000 0 fffffefb RD -
R 00000104 00000000 0 fffffefb - -
W 00000104 11111111 0 00000000 - -
R 00000104 00000000 0 11111111 - -
R 00000208 00000000 1 fffffdf7 RD -
W 00000208 22222222 0 00000000 INV -
R 00000208 00000000 0 22222222 - -
W 0000030c 33333333 0 00000000 RDX -
R 0000030c 00000000 0 33333333 - -
W 00001010 aaaa0001 0 00000000 RDX -
W 00002010 bbbb0002 0 00000000 RDX -
R 00001010 00000000 0 aaaa0001 - -
R 00003010 00000000 0 ffffcfef WR RD
R 00002010 00000000 0 bbbb0002 WR RD
R 00001010 00000000 0 aaaa0001 RD -
R 00001020 00000000 1 ffffefdf RD -
R 00002020 00000000 1 ffffdfdf RD -
R 00003020 00000000 0 ffffcfdf RD -
W 00001030 44444444 0 00000000 RDX -
W 00002030 55555555 0 00000000 RDX -
W 00003030 66666666 0 00000000 WR RDX
R 00001030 00000000 0 44444444 WR RD

/* verilog.f */
+incdir+.
l1d_pkg.sv
l1d_lookup_if.sv
l1d_data_if.sv
l1d_tag_array.sv
l1d_data_array.sv
l1d_ctrl.sv
l1d_top.sv
l1d_chk.sv
tb_l1d.sv

/* run_sim.sh */
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -f verilog.f --top-module tb_l1d -o tb_l1d
./obj_dir/tb_l1d | tee sim.log
if grep -qx '>>> PASS' sim.log; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi

/* tb_l1d.sv */
// reads l1d_tests.txt from the project root; the L2 model answers each command after 1 to 4 cycles
`timescale 1ns/1ps
`include "l1d_cfg.svh"

module tb_l1d import l1d_pkg::*; ();

    logic                   clk;
    logic                   rst;
    logic                   cpu_rd;
    logic                   cpu_wr;
    logic [`L1D_ADDR_W-1:0] cpu_addr;
    logic [`L1D_DATA_W-1:0] cpu_wdata;
    logic [`L1D_DATA_W-1:0] cpu_rdata;
    logic                   cpu_rdata_valid;
    logic                   cpu_wr_done;
    l2_cmd_e                l2_cmd;
    logic [`L1D_ADDR_W-1:0] l2_addr;
    logic [`L1D_DATA_W-1:0] l2_wdata;
    logic [`L1D_DATA_W-1:0] l2_rdata;
    logic                   l2_fill_valid;
    logic                   l2_fill_shared;
    logic                   l2_wr_done;
    logic                   all_inv_done;

    integer seed = 32002;
    int     errors;
    int     n_tests;
    int     cur_shared;
    int     n_done;

    // words never written back read as the inverted address
    logic [`L1D_DATA_W-1:0] l2_mem [logic [`L1D_ADDR_W-1:0]];
    l2_cmd_e                cmd_log [$];
    logic [`L1D_ADDR_W-1:0] addr_log [$];
    logic [`L1D_DATA_W-1:0] wdata_log [$];
    // last word the CPU wrote to each line
    logic [31:0]            cpu_written [logic [31:0]];

    string       op_q [$];
    logic [31:0] addr_q [$];
    logic [31:0] wdata_q [$];
    logic [31:0] rdata_q [$];
    logic [31:0] seq_q [$];
    int          shared_q [$];

    l1d_top i_dut (.*);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    task automatic check(input logic [31:0] actual, input logic [31:0] expected,
                         input string msg);
        if (actual !== expected) begin
            $display("CHECK FAILED at %0t: %s, got %h, expected %h",
                     $time, msg, actual, expected);
            errors++;
        end
    endtask

    function automatic logic [3:0] cmd_code(input string name);
        if (name == "RD") return {1'b0, L2_RD};
        if (name == "RDX") return {1'b0, L2_RDX};
        if (name == "WR") return {1'b0, L2_WR};
        if (name == "INV") return {1'b0, L2_INV};
        return 4'h0;
    endfunction

    // ==================================================
    // level 2 model
    // ==================================================
    initial begin : l2_model
        l2_cmd_e                cmd;
        logic [`L1D_ADDR_W-1:0] addr;
        int                     delay;
        n_done         = 0;
        l2_rdata       = '0;
        l2_fill_valid  = 1'b0;
        l2_fill_shared = 1'b0;
        l2_wr_done     = 1'b0;
        all_inv_done   = 1'b0;
        forever begin
            @(negedge clk);
            if (!rst && l2_cmd != L2_NONE) begin
                cmd  = l2_cmd;
                addr = l2_addr;
                cmd_log.push_back(cmd);
                addr_log.push_back(addr);
                wdata_log.push_back(l2_wdata);
                delay = 1 + int'($unsigned($random(seed)) % 4);
                repeat (delay) @(posedge clk);
                n_done++;
                case (cmd)
                    L2_WR: begin
                        l2_mem[addr] = l2_wdata;
                        l2_wr_done <= 1'b1;
                    end
                    L2_INV: all_inv_done <= 1'b1;
                    default: begin
                        l2_rdata       <= l2_mem.exists(addr) ? l2_mem[addr] : ~addr;
                        l2_fill_shared <= cur_shared[0];
                        l2_fill_valid  <= 1'b1;
                    end
                endcase
                // DUT samples the completion at this edge
                @(posedge clk);
                l2_wr_done    <= 1'b0;
                all_inv_done  <= 1'b0;
                l2_fill_valid <= 1'b0;
            end
        end
    end

    initial begin : watchdog
        wait (n_tests > 0);
        repeat (n_tests * 60 + 10) @(posedge clk);
        $display("timeout: the tests did not finish within %0d cycles", n_tests * 60 + 10);
        $display(">>> FAIL");
        $finish;
    end

    // ==================================================
    // test sequence
    // ==================================================
    initial begin : main
        string       line, op, c1, c2;
        logic [31:0] a, d, ed, seq;
        int          sh, fd, waits, errs_before, n_fail, log_start;
        logic        is_rd;
        errors     = 0;
        n_fail     = 0;
        cur_shared = 0;
        rst        = 1'b1;
        cpu_rd     = 1'b0;
        cpu_wr     = 1'b0;
        cpu_addr   = '0;
        cpu_wdata  = '0;
        fd = $fopen("l1d_tests.txt", "r");
        while (fd != 0 && !$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            if (line.len() > 1 && line.substr(0, 0) != "#" &&
                $sscanf(line, "%s %h %h %d %h %s %s", op, a, d, sh, ed, c1, c2) == 7) begin
                seq = '0;
                if (c1 != "-") seq = {seq[27:0], cmd_code(c1)};
                if (c2 != "-") seq = {seq[27:0], cmd_code(c2)};
                op_q.push_back(op);
                addr_q.push_back(a);
                wdata_q.push_back(d);
                shared_q.push_back(sh);
                rdata_q.push_back(ed);
                seq_q.push_back(seq);
            end
        end
        if (fd != 0) $fclose(fd);
        if (op_q.size() == 0) begin
            $display("no tests could be loaded from l1d_tests.txt");
            errors++;
        end
        n_tests = op_q.size();

        repeat (3) @(posedge clk);
        rst <= 1'b0;
        repeat (2) begin
            @(negedge clk);
            check(32'(l2_cmd), 32'(L2_NONE), "l2_cmd after reset");
            check(32'(cpu_rdata_valid | cpu_wr_done), 32'd0, "done pulse after reset");
        end

        for (int i = 0; i < n_tests; i++) begin
            errs_before = errors;
            log_start   = cmd_log.size();
            @(posedge clk);
            is_rd      = (op_q[i] == "R");
            cur_shared = shared_q[i];
            cpu_rd    <= is_rd;
            cpu_wr    <= !is_rd;
            cpu_addr  <= addr_q[i];
            cpu_wdata <= wdata_q[i];
            waits = 0;
            do begin
                @(negedge clk);
                waits++;
            end while (!cpu_rdata_valid && !cpu_wr_done);
            check(32'(cpu_rdata_valid), 32'(is_rd), "read valid pulse");
            check(32'(cpu_wr_done), 32'(!is_rd), "write done pulse");
            check(32'(n_done), 32'(cmd_log.size()), "level-2 commands completed before done");
            if (is_rd) check(cpu_rdata, rdata_q[i], "read data");
            seq = '0;
            for (int k = log_start; k < cmd_log.size(); k++) begin
                seq = {seq[27:0], 1'b0, cmd_log[k]};
                if (cmd_log[k] == L2_WR) begin
                    check(32'(addr_log[k][`L1D_OFS_W +: `L1D_IDX_W]),
                          32'(addr_q[i][`L1D_OFS_W +: `L1D_IDX_W]), "write-back set index");
                    if (cpu_written.exists(addr_log[k])) begin
                        check(wdata_log[k], cpu_written[addr_log[k]], "write-back data");
                    end else begin
                        $display("write-back of line %h, which the CPU never wrote",
                                 addr_log[k]);
                        errors++;
                    end
                end else begin
                    check(addr_log[k], {addr_q[i][31:2], 2'b00}, "level-2 line address");
                end
            end
            check(seq, seq_q[i], "level-2 command sequence");
            if (seq_q[i] == 0) check(32'(waits), 32'd2, "hit latency");
            if (!is_rd) cpu_written[{addr_q[i][31:2], 2'b00}] = wdata_q[i];
            @(posedge clk);
            cpu_rd <= 1'b0;
            cpu_wr <= 1'b0;
            if (errors != errs_before) n_fail++;
            $display("test %0d: %s %h %s", i, op_q[i], addr_q[i],
                     (errors == errs_before) ? "ok" : "mismatch");
        end

        $display("tests run %0d, tests failed %0d, mismatches %0d", n_tests, n_fail, errors);
        if (errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

/* l1d_chk.sv */
// protocol checks on the L1D top level ports; bound to every l1d_top instance
`timescale 1ns/1ps
`include "l1d_cfg.svh"

module l1d_chk import l1d_pkg::*; (
    input logic                   clk,
    input logic                   rst,
    input logic                   cpu_rdata_valid,
    input logic                   cpu_wr_done,
    input l2_cmd_e                l2_cmd,
    input logic [`L1D_ADDR_W-1:0] l2_addr,
    input logic                   l2_fill_valid,
    input logic                   l2_wr_done,
    input logic                   all_inv_done
);

    logic l2_complete;

    // completion input matching the pending command
    assign l2_complete = (l2_cmd == L2_WR)  ? l2_wr_done :
                         (l2_cmd == L2_INV) ? all_inv_done : l2_fill_valid;

    a_rd_pulse: assert property (@(posedge clk) disable iff (rst)
        cpu_rdata_valid |=> !cpu_rdata_valid)
        else $error("cpu_rdata_valid high for more than one cycle");

    a_wr_pulse: assert property (@(posedge clk) disable iff (rst)
        cpu_wr_done |=> !cpu_wr_done)
        else $error("cpu_wr_done high for more than one cycle");

    a_no_overlap: assert property (@(posedge clk) disable iff (rst)
        !(cpu_rdata_valid && cpu_wr_done))
        else $error("read and write done pulses high together");

    a_cmd_hold: assert property (@(posedge clk) disable iff (rst)
        (l2_cmd != L2_NONE && !l2_complete) |=>
            (l2_cmd == $past(l2_cmd) && l2_addr == $past(l2_addr)))
        else $error("l2 command changed before its completion");

    a_after_rst: assert property (@(posedge clk) rst |=> l2_cmd == L2_NONE)
        else $error("l2_cmd not idle after reset");

endmodule

bind l1d_top l1d_chk i_chk (.*);

/* l1d_top.sv */
// L1 data cache top with plain ports; L2 must hold its response inputs low when idle
`timescale 1ns/1ps
`include "l1d_cfg.svh"

module l1d_top import l1d_pkg::*; (
    input  logic                   clk,
    input  logic                   rst,

    // CPU side
    input  logic                   cpu_rd,
    input  logic                   cpu_wr,
    input  logic [`L1D_ADDR_W-1:0] cpu_addr,
    input  logic [`L1D_DATA_W-1:0] cpu_wdata,
    output logic [`L1D_DATA_W-1:0] cpu_rdata,
    output logic                   cpu_rdata_valid,
    output logic                   cpu_wr_done,

    // level 2 side
    output l2_cmd_e                l2_cmd,
    output logic [`L1D_ADDR_W-1:0] l2_addr,
    output logic [`L1D_DATA_W-1:0] l2_wdata,
    input  logic [`L1D_DATA_W-1:0] l2_rdata,
    input  logic                   l2_fill_valid,
    input  logic                   l2_fill_shared,
    input  logic                   l2_wr_done,
    input  logic                   all_inv_done
);

    l1d_lookup_if lk_if ();
    l1d_data_if   dt_if ();

    l1d_ctrl i_ctrl (
        .clk             (clk),
        .rst             (rst),
        .cpu_rd          (cpu_rd),
        .cpu_wr          (cpu_wr),
        .cpu_addr        (cpu_addr),
        .cpu_wdata       (cpu_wdata),
        .l2_rdata        (l2_rdata),
        .l2_fill_valid   (l2_fill_valid),
        .l2_fill_shared  (l2_fill_shared),
        .l2_wr_done      (l2_wr_done),
        .all_inv_done    (all_inv_done),
        .cpu_rdata       (cpu_rdata),
        .cpu_rdata_valid (cpu_rdata_valid),
        .cpu_wr_done     (cpu_wr_done),
        .l2_cmd          (l2_cmd),
        .l2_addr         (l2_addr),
        .l2_wdata        (l2_wdata),
        .lk              (lk_if.ctrl),
        .dt              (dt_if.ctrl)
    );

    l1d_tag_array i_tag_array (
        .clk (clk),
        .rst (rst),
        .lk  (lk_if.tags)
    );

    l1d_data_array i_data_array (
        .clk (clk),
        .dt  (dt_if.data)
    );

endmodule

/* l1d_ctrl.sv */
// blocking controller, one CPU request at a time; the CPU must hold its request until done
`timescale 1ns/1ps
`include "l1d_cfg.svh"

module l1d_ctrl import l1d_pkg::*; (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   cpu_rd,
    input  logic                   cpu_wr,
    input  logic [`L1D_ADDR_W-1:0] cpu_addr,
    input  logic [`L1D_DATA_W-1:0] cpu_wdata,
    input  logic [`L1D_DATA_W-1:0] l2_rdata,
    input  logic                   l2_fill_valid,
    input  logic                   l2_fill_shared,
    input  logic                   l2_wr_done,
    input  logic                   all_inv_done,
    output logic [`L1D_DATA_W-1:0] cpu_rdata,
    output logic                   cpu_rdata_valid,
    output logic                   cpu_wr_done,
    output l2_cmd_e                l2_cmd,
    output logic [`L1D_ADDR_W-1:0] l2_addr,
    output logic [`L1D_DATA_W-1:0] l2_wdata,
    l1d_lookup_if.ctrl             lk,
    l1d_data_if.ctrl               dt
);

    ctrl_state_e           state;
    logic                  req_wr;
    logic [`L1D_WAY_W-1:0] req_way;
    logic [`L1D_ADDR_W-1:0] line_addr;
    logic [`L1D_ADDR_W-1:0] victim_addr;

    assign lk.lookup_idx = cpu_addr[`L1D_OFS_W +: `L1D_IDX_W];
    assign lk.lookup_tag = cpu_addr[`L1D_ADDR_W-1 -: `L1D_TAG_W];
    assign lk.upd_tag    = lk.lookup_tag;
    assign dt.idx        = lk.lookup_idx;

    assign line_addr   = {lk.lookup_tag, lk.lookup_idx, {`L1D_OFS_W{1'b0}}};
    assign victim_addr = {lk.victim_tag, lk.lookup_idx, {`L1D_OFS_W{1'b0}}};

    // ==================================================
    // array control
    // ==================================================
    always_comb begin
        lk.upd_en    = 1'b0;
        lk.upd_way   = req_way;
        lk.upd_mesi  = MESI_I;
        lk.lru_touch = 1'b0;
        dt.way       = req_way;
        dt.wr_en     = 1'b0;
        dt.wdata     = cpu_wdata;
        case (state)
            ST_IDLE: begin
                dt.way     = lk.hit ? lk.hit_way : lk.victim_way;
                lk.upd_way = lk.hit_way;
                if (cpu_rd && lk.hit) begin
                    lk.lru_touch = 1'b1;
                end else if (cpu_wr && lk.hit && lk.hit_mesi != MESI_S) begin
                    lk.upd_en    = 1'b1;
                    lk.upd_mesi  = MESI_M;
                    lk.lru_touch = 1'b1;
                    dt.wr_en     = 1'b1;
                end
            end
            ST_WB: begin
                // dirty victim is gone once L2 has it
                lk.upd_en = l2_wr_done;
            end
            ST_FILL: begin
                if (l2_fill_valid) begin
                    lk.upd_en    = 1'b1;
                    lk.lru_touch = 1'b1;
                    dt.wr_en     = 1'b1;
                    if (req_wr) begin
                        lk.upd_mesi = MESI_M;
                    end else begin
                        lk.upd_mesi = l2_fill_shared ? MESI_S : MESI_E;
                        dt.wdata    = l2_rdata;
                    end
                end
            end
            ST_INV: begin
                if (all_inv_done) begin
                    lk.upd_en    = 1'b1;
                    lk.upd_mesi  = MESI_M;
                    lk.lru_touch = 1'b1;
                    dt.wr_en     = 1'b1;
                end
            end
            default: ;
        endcase
    end

    // ==================================================
    // request FSM
    // ==================================================
    always_ff @(posedge clk) begin
        if (rst) begin
            state           <= ST_IDLE;
            l2_cmd          <= L2_NONE;
            cpu_rdata_valid <= 1'b0;
            cpu_wr_done     <= 1'b0;
            req_wr          <= 1'b0;
            req_way         <= '0;
        end else begin
            cpu_rdata_valid <= 1'b0;
            cpu_wr_done     <= 1'b0;
            case (state)
                ST_IDLE: begin
                    if (cpu_rd || cpu_wr) begin
                        req_wr  <= cpu_wr;
                        req_way <= lk.hit ? lk.hit_way : lk.victim_way;
                        if (lk.hit && cpu_rd) begin
                            cpu_rdata       <= dt.rdata;
                            cpu_rdata_valid <= 1'b1;
                            state           <= ST_RESP;
                        end else if (lk.hit && lk.hit_mesi == MESI_S) begin
                            // other copies must go before we own it
                            l2_cmd  <= L2_INV;
                            l2_addr <= line_addr;
                            state   <= ST_INV;
                        end else if (lk.hit) begin
                            cpu_wr_done <= 1'b1;
                            state       <= ST_RESP;
                        end else if (lk.victim_mesi == MESI_M) begin
                            l2_cmd   <= L2_WR;
                            l2_addr  <= victim_addr;
                            l2_wdata <= dt.rdata;
                            state    <= ST_WB;
                        end else begin
                            l2_cmd  <= cpu_wr ? L2_RDX : L2_RD;
                            l2_addr <= line_addr;
                            state   <= ST_FILL;
                        end
                    end
                end
                ST_WB: begin
                    if (l2_wr_done) begin
                        l2_cmd  <= req_wr ? L2_RDX : L2_RD;
                        l2_addr <= line_addr;
                        state   <= ST_FILL;
                    end
                end
                ST_FILL: begin
                    if (l2_fill_valid) begin
                        l2_cmd <= L2_NONE;
                        if (req_wr) begin
                            cpu_wr_done <= 1'b1;
                        end else begin
                            cpu_rdata       <= l2_rdata;
                            cpu_rdata_valid <= 1'b1;
                        end
                        state <= ST_RESP;
                    end
                end
                ST_INV: begin
                    if (all_inv_done) begin
                        l2_cmd      <= L2_NONE;
                        cpu_wr_done <= 1'b1;
                        state       <= ST_RESP;
                    end
                end
                // one dead cycle so the CPU can drop its request
                ST_RESP: state <= ST_IDLE;
                default: state <= ST_IDLE;
            endcase
        end
    end

endmodule

/* l1d_data_array.sv */
// one word per set and way; contents are undefined until a line is filled
`timescale 1ns/1ps
`include "l1d_cfg.svh"

module l1d_data_array (
    input logic       clk,
    l1d_data_if.data  dt
);

    localparam int SETS = 1 << `L1D_IDX_W;

    logic [`L1D_DATA_W-1:0] mem [SETS][`L1D_WAYS];

    // combinational read
    assign dt.rdata = mem[dt.idx][dt.way];

    always_ff @(posedge clk) begin
        if (dt.wr_en) begin
            mem[dt.idx][dt.way] <= dt.wdata;
        end
    end

endmodule

/* l1d_tag_array.sv */
// tag, MESI and LRU storage for 2 ways only; reset invalidates all lines, tags are left as is
`timescale 1ns/1ps
`include "l1d_cfg.svh"

module l1d_tag_array import l1d_pkg::*; (
    input logic       clk,
    input logic       rst,
    l1d_lookup_if.tags lk
);

    localparam int SETS = 1 << `L1D_IDX_W;

    logic [`L1D_TAG_W-1:0] tag_mem  [SETS][`L1D_WAYS];
    mesi_e                 mesi_mem [SETS][`L1D_WAYS];
    // names the most recently used way
    logic [`L1D_WAY_W-1:0] lru      [SETS];

    logic                  free_found;
    logic [`L1D_WAY_W-1:0] free_way;

    // ==================================================
    // lookup
    // ==================================================
    always_comb begin
        lk.hit      = 1'b0;
        lk.hit_way  = '0;
        lk.hit_mesi = MESI_I;
        for (int w = 0; w < `L1D_WAYS; w++) begin
            if (!lk.hit && mesi_mem[lk.lookup_idx][w] != MESI_I &&
                tag_mem[lk.lookup_idx][w] == lk.lookup_tag) begin
                lk.hit      = 1'b1;
                lk.hit_way  = w[`L1D_WAY_W-1:0];
                lk.hit_mesi = mesi_mem[lk.lookup_idx][w];
            end
        end
    end

    // lowest invalid way wins
    always_comb begin
        free_found = 1'b0;
        free_way   = '0;
        for (int w = 0; w < `L1D_WAYS; w++) begin
            if (!free_found && mesi_mem[lk.lookup_idx][w] == MESI_I) begin
                free_found = 1'b1;
                free_way   = w[`L1D_WAY_W-1:0];
            end
        end
    end

    // otherwise the way the LRU bit does not name
    assign lk.victim_way  = free_found ? free_way : ~lru[lk.lookup_idx];
    assign lk.victim_mesi = mesi_mem[lk.lookup_idx][lk.victim_way];
    assign lk.victim_tag  = tag_mem[lk.lookup_idx][lk.victim_way];

    // ==================================================
    // update
    // ==================================================
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int s = 0; s < SETS; s++) begin
                lru[s] <= '0;
                for (int w = 0; w < `L1D_WAYS; w++) begin
                    mesi_mem[s][w] <= MESI_I;
                end
            end
        end else begin
            if (lk.upd_en) begin
                mesi_mem[lk.lookup_idx][lk.upd_way] <= lk.upd_mesi;
            end
            if (lk.lru_touch) begin
                lru[lk.lookup_idx] <= lk.upd_en ? lk.upd_way : lk.hit_way;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (lk.upd_en) begin
            tag_mem[lk.lookup_idx][lk.upd_way] <= lk.upd_tag;
        end
    end

endmodule

/* l1d_data_if.sv */
// data array port; read is combinational at idx/way, write lands on the next edge
`timescale 1ns/1ps
`include "l1d_cfg.svh"

interface l1d_data_if ();

    logic [`L1D_IDX_W-1:0]  idx;
    logic [`L1D_WAY_W-1:0]  way;
    logic                   wr_en;
    logic [`L1D_DATA_W-1:0] wdata;
    logic [`L1D_DATA_W-1:0] rdata;

    modport ctrl (output idx, way, wr_en, wdata, input rdata);

    modport data (input idx, way, wr_en, wdata, output rdata);

endinterface

/* l1d_lookup_if.sv */
// lookup and update path between controller and tag array; results are combinational
`timescale 1ns/1ps
`include "l1d_cfg.svh"

interface l1d_lookup_if import l1d_pkg::*; ();

    // request address fields
    logic [`L1D_IDX_W-1:0] lookup_idx;
    logic [`L1D_TAG_W-1:0] lookup_tag;

    // entry update, one way per cycle
    logic                  upd_en;
    logic [`L1D_WAY_W-1:0] upd_way;
    mesi_e                 upd_mesi;
    logic [`L1D_TAG_W-1:0] upd_tag;
    logic                  lru_touch;

    // lookup results
    logic                  hit;
    logic [`L1D_WAY_W-1:0] hit_way;
    mesi_e                 hit_mesi;
    logic [`L1D_WAY_W-1:0] victim_way;
    mesi_e                 victim_mesi;
    logic [`L1D_TAG_W-1:0] victim_tag;

    modport ctrl (
        output lookup_idx, lookup_tag, upd_en, upd_way, upd_mesi, upd_tag, lru_touch,
        input  hit, hit_way, hit_mesi, victim_way, victim_mesi, victim_tag
    );

    modport tags (
        input  lookup_idx, lookup_tag, upd_en, upd_way, upd_mesi, upd_tag, lru_touch,
        output hit, hit_way, hit_mesi, victim_way, victim_mesi, victim_tag
    );

endinterface

/* l1d_pkg.sv */
// MESI, L2 opcode and controller state encodings; no snoop side states are kept here
package l1d_pkg;

    typedef enum logic [1:0] {
        MESI_I = 2'b00,
        MESI_S = 2'b01,
        MESI_E = 2'b10,
        MESI_M = 2'b11
    } mesi_e;

    // opcodes toward level 2
    typedef enum logic [2:0] {
        L2_NONE = 3'd0,
        L2_RD   = 3'd1,
        L2_RDX  = 3'd2,
        L2_WR   = 3'd3,
        L2_INV  = 3'd4
    } l2_cmd_e;

    typedef enum logic [2:0] {
        ST_IDLE = 3'd0,
        ST_WB   = 3'd1,
        ST_FILL = 3'd2,
        ST_INV  = 3'd3,
        ST_RESP = 3'd4
    } ctrl_state_e;

endpackage

/* l1d_cfg.svh */
// geometry of the 2-way, 16-set L1 data cache; tag width must equal addr - idx - ofs widths
`ifndef L1D_CFG_SVH
`define L1D_CFG_SVH

// ==================================================
// address and data
// ==================================================
`define L1D_ADDR_W 32
`define L1D_DATA_W 32

// byte offset, ignored on lookup, zero toward L2
`define L1D_OFS_W 2

// ==================================================
// set and way organisation
// ==================================================
`define L1D_IDX_W 4
`define L1D_TAG_W 26

// victim logic relies on exactly two ways
`define L1D_WAYS 2
`define L1D_WAY_W 1

`endif
